//--- rtl/display_pkg.sv
//----------------------------------------
// Display geometry, address types and command opcodes shared by the
// command front end. Modules pull it in with a wildcard import.
//----------------------------------------
package display_pkg;

    // Frame geometry.
    localparam int ROW_BITS        = 4;
    localparam int COL_BITS        = 9;
    localparam int BYTES_PER_PIXEL = 3;

    // Column numbers travel little-endian over this many bytes.
    localparam int COL_BYTES = (COL_BITS + 7) / 8;

    // Counter widths never drop below one bit.
    localparam int PIX_BITS     = (BYTES_PER_PIXEL > 1) ? $clog2(BYTES_PER_PIXEL) : 1;
    localparam int COL_CNT_BITS = (COL_BYTES > 1) ? $clog2(COL_BYTES) : 1;

    // Frame RAM size in bytes.
    localparam int RAM_DEPTH     = (1 << ROW_BITS) * (1 << COL_BITS) * BYTES_PER_PIXEL;
    localparam int RAM_ADDR_BITS = $clog2(RAM_DEPTH);

    typedef logic [ROW_BITS-1:0] row_addr_t;
    typedef logic [COL_BITS-1:0] col_addr_t;
    typedef logic [PIX_BITS-1:0] pixel_idx_t;

    // Command opcodes.
    localparam logic [7:0] OPC_LOAD_PIXEL  = 8'h01;
    localparam logic [7:0] OPC_FETCH_PIXEL = 8'h02;

endpackage

//--- rtl/pixel_bus_if.sv
//----------------------------------------
// One frame RAM access port. Handlers drive the requester side,
// the RAM (or the arbiter on its behalf) serves the memory side.
//----------------------------------------
`timescale 1ns/100ps

interface pixel_bus_if
    import display_pkg::*;
();

    row_addr_t  row;
    col_addr_t  column;
    pixel_idx_t pixel;
    logic [7:0] wdata;
    logic       write_en;
    logic       read_en;
    logic [7:0] rdata;

    modport requester (
        output row, column, pixel, wdata, write_en, read_en,
        input  rdata
    );

    modport memory (
        input  row, column, pixel, wdata, write_en, read_en,
        output rdata
    );

endinterface

//--- rtl/cmd_dispatch.sv
//----------------------------------------
// Decodes opcodes from the input stream, routes argument bytes
// to the active handler and gives that handler the frame RAM.
//----------------------------------------
`timescale 1ns/100ps

module cmd_dispatch
    import display_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic [7:0]       in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [7:0]       load_data,
    output logic             load_strobe,
    input  logic             load_done,
    output logic [7:0]       fetch_data,
    output logic             fetch_strobe,
    input  logic             fetch_done,
    input  logic             fetch_hold,
    pixel_bus_if.memory      load_bus,
    pixel_bus_if.memory      fetch_bus,
    pixel_bus_if.requester   ram_bus
);

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_fetch,
        st_finish
    } disp_state_t;

    disp_state_t state;
    logic        accept;
    logic        fetch_sel;

    assign accept    = in_valid && in_ready;
    assign fetch_sel = (state == st_fetch);

    // The fetch handler stalls input while it reads and streams.
    always_comb begin
        case (state)
            st_idle:  in_ready = 1'b1;
            st_load:  in_ready = !load_done;
            st_fetch: in_ready = !(fetch_hold || fetch_bus.read_en || fetch_done);
            default:  in_ready = 1'b0;
        endcase
    end

    // Reset parks the FSM in finish so in_ready stays low until idle.
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_finish;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        if (in_data == OPC_LOAD_PIXEL) begin
                            state <= st_load;
                        end else if (in_data == OPC_FETCH_PIXEL) begin
                            state <= st_fetch;
                        end
                        // Anything else is dropped here.
                    end
                end
                st_load: begin
                    if (load_done) begin
                        state <= st_finish;
                    end
                end
                st_fetch: begin
                    if (fetch_done) begin
                        state <= st_finish;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Argument bytes go straight through and the strobes qualify them.
    assign load_data    = in_data;
    assign fetch_data   = in_data;
    assign load_strobe  = accept && (state == st_load);
    assign fetch_strobe = accept && fetch_sel;

    // Only the active handler's enables reach the RAM port.
    assign ram_bus.row      = fetch_sel ? fetch_bus.row : load_bus.row;
    assign ram_bus.column   = fetch_sel ? fetch_bus.column : load_bus.column;
    assign ram_bus.pixel    = fetch_sel ? fetch_bus.pixel : load_bus.pixel;
    assign ram_bus.wdata    = fetch_sel ? fetch_bus.wdata : load_bus.wdata;
    assign ram_bus.write_en = (state == st_load) && load_bus.write_en;
    assign ram_bus.read_en  = fetch_sel && fetch_bus.read_en;

    assign load_bus.rdata  = ram_bus.rdata;
    assign fetch_bus.rdata = ram_bus.rdata;

endmodule

//--- rtl/cmd_load_pixel.sv
//----------------------------------------
// Load-pixel handler. Takes row, column and channel bytes from
// the dispatcher and writes each channel byte to the frame RAM.
//----------------------------------------
`timescale 1ns/100ps

module cmd_load_pixel
    import display_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic [7:0]     byte_data,
    input  logic           byte_strobe,
    pixel_bus_if.requester bus,
    output logic           done
);

    typedef enum logic [1:0] {
        st_row,
        st_col,
        st_data
    } load_state_t;

    load_state_t             state;
    logic [COL_CNT_BITS-1:0] col_cnt;
    pixel_idx_t              pix_cnt;
    logic                    write_en;

    row_addr_t               row;
    logic [COL_BYTES*8-1:0]  col_bytes;
    pixel_idx_t              wr_pixel;
    logic [7:0]              wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_row;
            col_cnt  <= '0;
            pix_cnt  <= '0;
            write_en <= 1'b0;
            done     <= 1'b0;
        end else begin
            write_en <= 1'b0;
            done     <= 1'b0;
            case (state)
                st_row: begin
                    if (byte_strobe) begin
                        col_cnt <= COL_CNT_BITS'(COL_BYTES - 1);
                        state   <= st_col;
                    end
                end
                st_col: begin
                    if (byte_strobe) begin
                        if (col_cnt == '0) begin
                            pix_cnt <= pixel_idx_t'(BYTES_PER_PIXEL - 1);
                            state   <= st_data;
                        end else begin
                            col_cnt <= col_cnt - 1'b1;
                        end
                    end
                end
                st_data: begin
                    // Each data byte becomes a write in the following cycle.
                    if (byte_strobe) begin
                        write_en <= 1'b1;
                        if (pix_cnt == '0) begin
                            done  <= 1'b1;
                            state <= st_row;
                        end else begin
                            pix_cnt <= pix_cnt - 1'b1;
                        end
                    end
                end
                default: state <= st_row;
            endcase
        end
    end

    // Address and data capture.
    always_ff @(posedge clk) begin
        if (byte_strobe) begin
            case (state)
                st_row: row <= byte_data[ROW_BITS-1:0];
                // The first column byte lands in the low bits.
                st_col: col_bytes[(COL_BYTES - 1 - col_cnt) * 8 +: 8] <= byte_data;
                st_data: begin
                    wdata    <= byte_data;
                    wr_pixel <= pix_cnt;
                end
                default: ;
            endcase
        end
    end

    assign bus.row      = row;
    assign bus.column   = col_bytes[COL_BITS-1:0];
    assign bus.pixel    = wr_pixel;
    assign bus.wdata    = wdata;
    assign bus.write_en = write_en;
    assign bus.read_en  = 1'b0;

endmodule

//--- rtl/cmd_fetch_pixel.sv
//----------------------------------------
// Fetch-pixel handler. Takes row and column, then reads each
// channel byte and streams it out on a valid/ready port.
//----------------------------------------
`timescale 1ns/100ps

module cmd_fetch_pixel
    import display_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic [7:0]     byte_data,
    input  logic           byte_strobe,
    output logic           hold,
    pixel_bus_if.requester bus,
    output logic [7:0]     out_data,
    output logic           out_valid,
    input  logic           out_ready,
    output logic           done
);

    typedef enum logic [2:0] {
        st_row,
        st_col,
        st_issue,
        st_wait,
        st_send,
        st_done
    } fetch_state_t;

    fetch_state_t            state;
    logic [COL_CNT_BITS-1:0] col_cnt;
    pixel_idx_t              pix_cnt;

    row_addr_t               row;
    logic [COL_BYTES*8-1:0]  col_bytes;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_row;
            col_cnt <= '0;
            pix_cnt <= '0;
        end else begin
            case (state)
                st_row: begin
                    if (byte_strobe) begin
                        col_cnt <= COL_CNT_BITS'(COL_BYTES - 1);
                        state   <= st_col;
                    end
                end
                st_col: begin
                    if (byte_strobe) begin
                        if (col_cnt == '0) begin
                            pix_cnt <= pixel_idx_t'(BYTES_PER_PIXEL - 1);
                            state   <= st_issue;
                        end else begin
                            col_cnt <= col_cnt - 1'b1;
                        end
                    end
                end
                st_issue: state <= st_wait;
                // RAM data is valid during this cycle.
                st_wait:  state <= st_send;
                st_send: begin
                    if (out_ready) begin
                        if (pix_cnt == '0) begin
                            state <= st_done;
                        end else begin
                            pix_cnt <= pix_cnt - 1'b1;
                            state   <= st_issue;
                        end
                    end
                end
                default: state <= st_row;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (byte_strobe && state == st_row) begin
            row <= byte_data[ROW_BITS-1:0];
        end
        if (byte_strobe && state == st_col) begin
            col_bytes[(COL_BYTES - 1 - col_cnt) * 8 +: 8] <= byte_data;
        end
        if (state == st_wait) begin
            out_data <= bus.rdata;
        end
    end

    // Input stalls from the last column byte until the command ends.
    assign hold      = (state == st_issue) || (state == st_wait) || (state == st_send);
    assign out_valid = (state == st_send);
    assign done      = (state == st_done);

    assign bus.row      = row;
    assign bus.column   = col_bytes[COL_BITS-1:0];
    assign bus.pixel    = pix_cnt;
    assign bus.wdata    = '0;
    assign bus.write_en = 1'b0;
    assign bus.read_en  = (state == st_issue);

endmodule

//--- rtl/frame_ram.sv
//----------------------------------------
// Byte-wide frame memory with synchronous write and registered
// read. It serves the memory side of one pixel bus.
//----------------------------------------
`timescale 1ns/100ps

module frame_ram
    import display_pkg::*;
(
    input  logic        clk,
    pixel_bus_if.memory bus
);

    logic [7:0]               mem [RAM_DEPTH];
    logic [RAM_ADDR_BITS-1:0] addr;

    // Pixels are packed row-major, channel bytes kept together.
    assign addr = RAM_ADDR_BITS'({bus.row, bus.column} * BYTES_PER_PIXEL + bus.pixel);

    always_ff @(posedge clk) begin
        if (bus.write_en) begin
            mem[addr] <= bus.wdata;
        end
        if (bus.read_en) begin
            bus.rdata <= mem[addr];
        end
    end

endmodule

//--- rtl/display_cmd_top.sv
//----------------------------------------
// Command front end top level. Host bytes in, fetched pixel bytes out.
//----------------------------------------
`timescale 1ns/100ps

module display_cmd_top (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,
    output logic [7:0] out_data,
    output logic       out_valid,
    input  logic       out_ready
);

    logic [7:0] load_data;
    logic       load_strobe;
    logic       load_done;
    logic [7:0] fetch_data;
    logic       fetch_strobe;
    logic       fetch_done;
    logic       fetch_hold;

    pixel_bus_if load_bus ();
    pixel_bus_if fetch_bus ();
    pixel_bus_if ram_bus ();

    cmd_dispatch u_dispatch (
        .clk          (clk),
        .reset        (reset),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .load_data    (load_data),
        .load_strobe  (load_strobe),
        .load_done    (load_done),
        .fetch_data   (fetch_data),
        .fetch_strobe (fetch_strobe),
        .fetch_done   (fetch_done),
        .fetch_hold   (fetch_hold),
        .load_bus     (load_bus),
        .fetch_bus    (fetch_bus),
        .ram_bus      (ram_bus)
    );

    cmd_load_pixel u_load (
        .clk         (clk),
        .reset       (reset),
        .byte_data   (load_data),
        .byte_strobe (load_strobe),
        .bus         (load_bus),
        .done        (load_done)
    );

    cmd_fetch_pixel u_fetch (
        .clk         (clk),
        .reset       (reset),
        .byte_data   (fetch_data),
        .byte_strobe (fetch_strobe),
        .hold        (fetch_hold),
        .bus         (fetch_bus),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .done        (fetch_done)
    );

    frame_ram u_ram (
        .clk (clk),
        .bus (ram_bus)
    );

endmodule

//--- verif/display_cmd_assert.sv
//----------------------------------------
// Handshake and frame RAM port checks, bound into the top level.
//----------------------------------------
`timescale 1ns/100ps

module display_cmd_assert (
    input logic       clk,
    input logic       reset,
    input logic       in_ready,
    input logic [7:0] out_data,
    input logic       out_valid,
    input logic       out_ready,
    input logic       ram_write_en,
    input logic       ram_read_en
);

    int violations = 0;

    // A stalled output byte holds until it transfers.
    out_hold_a: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        violations++;
        $error("out_valid or out_data changed while out_ready was low");
    end

    // One RAM access per cycle.
    ram_excl_a: assert property (@(posedge clk) !(ram_write_en && ram_read_en))
    else begin
        violations++;
        $error("frame RAM saw a write and a read in the same cycle");
    end

    // Both handshake outputs stay low once reset has taken hold.
    reset_quiet_a: assert property (@(posedge clk)
        reset && $past(reset) |-> !in_ready && !out_valid)
    else begin
        violations++;
        $error("in_ready or out_valid high during reset");
    end

endmodule

//--- verif/display_cmd_tb.sv
//----------------------------------------
// Testbench for the display command front end. Replays the vector
// file with random input gaps and output stalls, checks every byte.
//----------------------------------------
`timescale 1ns/100ps

module display_cmd_tb;

    logic       clk;
    logic       reset;
    logic [7:0] in_data;
    logic       in_valid;
    logic       in_ready;
    logic [7:0] out_data;
    logic       out_valid;
    logic       out_ready;

    logic [11:0] vec_mem [0:255];
    logic [7:0]  in_bytes[$];
    logic [7:0]  exp_bytes[$];
    integer      seed = 86;
    int          in_pos = 0;
    int          out_pos = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 200;

    display_cmd_top dut_i (.*);

    bind display_cmd_top display_cmd_assert assert_i (
        .clk (clk), .reset (reset), .in_ready (in_ready), .out_data (out_data),
        .out_valid (out_valid), .out_ready (out_ready),
        .ram_write_en (ram_bus.write_en), .ram_read_en (ram_bus.read_en)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_byte(input logic [7:0] actual, input logic [7:0] expected,
                              input int pos);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: output byte %0d is %h, expected %h",
                     $time, pos, actual, expected);
            mismatches++;
        end
    endtask

    // A vector word 1xx is a byte for the DUT and 2xx a byte expected back.
    initial begin : stimulus
        int i;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_data   = 8'h00;
        out_ready = 1'b0;
        $readmemh("verif/display_cmd_vectors.txt", vec_mem);
        for (i = 0; i < 256; i++) begin
            if (vec_mem[i][11:8] == 4'h1) begin
                in_bytes.push_back(vec_mem[i][7:0]);
            end else if (vec_mem[i][11:8] == 4'h2) begin
                exp_bytes.push_back(vec_mem[i][7:0]);
            end else begin
                break;
            end
        end
        cycle_limit = 40 * i + 200;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        forever begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                in_pos = in_pos + 1;
            end
            // A byte on offer stays put until it is taken.
            if (!in_valid || in_ready) begin
                if (in_pos < in_bytes.size() && ($random(seed) & 3) != 0) begin
                    in_valid <= 1'b1;
                    in_data  <= in_bytes[in_pos];
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= ($random(seed) & 3) != 0;
        end
    end

    // Output monitor and run limit.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (!reset && out_valid && out_ready) begin
            if (out_pos < exp_bytes.size()) begin
                check_byte(out_data, exp_bytes[out_pos], out_pos);
            end else begin
                $display("Surplus output byte %h at time %0t beyond the expected stream",
                         out_data, $time);
                other_errors++;
            end
            out_pos++;
        end
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // The last command is a fetch, so in_ready returning high marks the end.
    initial begin : finish_run
        int assert_fails;
        @(negedge reset);
        if (in_bytes.size() == 0) begin
            $display("No input bytes were read from the vector file");
            other_errors++;
        end
        while (in_pos < in_bytes.size()) @(posedge clk);
        while (in_ready) @(posedge clk);
        while (!in_ready) @(posedge clk);
        repeat (10) @(posedge clk);
        if (out_pos != exp_bytes.size()) begin
            $display("Wrong number of output bytes: received %0d, expected %0d",
                     out_pos, exp_bytes.size());
            other_errors++;
        end
        assert_fails = dut_i.assert_i.violations;
        $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, other_errors, assert_fails);
        if (mismatches + other_errors + assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verif/display_cmd_vectors.txt
// Words are tag then byte: 1xx is an input byte, 2xx an expected output byte.
// One command per line; a fetch line carries the bytes it should return.
101 101 105 100 1AA 1BB 1CC
102 101 105 100 2AA 2BB 2CC
101 102 123 101 111 122 133
101 103 123 100 144 155 166
102 102 123 101 211 222 233
102 103 123 100 244 255 266
100 1FF
101 104 107 100 101 102 103
101 104 107 100 1A1 1B2 1C3
17E
102 104 107 100 2A1 2B2 2C3
101 1F5 140 1FE 1D1 1D2 1D3
102 105 140 100 2D1 2D2 2D3
101 106 1C8 100 1E1 1E2 1E3
102 1B6 1C8 1FE 2E1 2E2 2E3
103 1C0
102 101 105 100 2AA 2BB 2CC

//--- verilog.f
rtl/display_pkg.sv
rtl/pixel_bus_if.sv
rtl/cmd_dispatch.sv
rtl/cmd_load_pixel.sv
rtl/cmd_fetch_pixel.sv
rtl/frame_ram.sv
rtl/display_cmd_top.sv
verif/display_cmd_assert.sv
verif/display_cmd_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the display command testbench with Verilator.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module display_cmd_tb -o display_cmd_sim

./obj_dir/display_cmd_sim 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
